// File: hdl/rbcpDecode.sv
//--------------------------------------------------------------------
// RBCP input stage
// Registers the access strobes, write data and register index and
// turns the address into a one-hot bank select for 0x00 to 0x7F
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module rbcpDecode (
  input  wire logic                 CLK,
  input  wire logic                 RST,
  // RBCP side
  input  wire rbcpRegPkg::rbcpAddrT rbcpAddr_i,
  input  wire logic                 rbcpWe_i,   // one cycle write strobe
  input  wire logic                 rbcpRe_i,   // one cycle read strobe
  input  wire rbcpRegPkg::byteT     rbcpWd_i,
  // decoded access
  output rbcpRegPkg::bankSelT       bankSel_o,
  output rbcpRegPkg::regIdxT        regIdx_o,
  output logic                      accWe_o,
  output logic                      accRe_o,
  output rbcpRegPkg::byteT          accWd_o
);

  import rbcpRegPkg::*;

  logic                 inRange;
  logic [bankWidth-1:0] bankIdx;
  bankSelT              bankSelNext;

  //--------------------------------------------------------------------
  // address decode
  //--------------------------------------------------------------------
  assign inRange = (rbcpAddr_i[rbcpAddrWidth-1:regAddrWidth] == '0); // below 0x80
  assign bankIdx = rbcpAddr_i[regAddrWidth-1:idxWidth];              // 16 byte window

  always_comb begin
    bankSelNext = '0;
    if (inRange) begin
      bankSelNext[bankIdx] = 1'b1;
    end
  end

  //--------------------------------------------------------------------
  // input register
  //--------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      bankSel_o <= '0;
      accWe_o   <= 1'b0;
      accRe_o   <= 1'b0;
    end else begin
      bankSel_o <= bankSelNext;
      accWe_o   <= rbcpWe_i;
      accRe_o   <= rbcpRe_i;
    end
  end

  // payload, qualified downstream by the strobes
  always_ff @(posedge CLK) begin
    regIdx_o <= rbcpAddr_i[idxWidth-1:0];
    accWd_o  <= rbcpWd_i;
  end

  //--------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------
  // at most one bank may claim an access
  bankSelOneHot : assert property (
    @(posedge CLK) disable iff (RST)
    $onehot0(bankSel_o)
  ) else $error("ERROR bankSel_o not one-hot: %h", bankSel_o);

endmodule

`default_nettype wire

// File: hdl/rbcpRegPkg.sv
//--------------------------------------------------------------------
// RBCP register file shared definitions
// Bus and register widths, the address map of the fixed registers
// and the identification values read back by the host
//--------------------------------------------------------------------
`default_nettype none

package rbcpRegPkg;

  //--------------------------------------------------------------------
  // widths and geometry
  //--------------------------------------------------------------------
  localparam int rbcpAddrWidth = 32;                    // full RBCP address
  localparam int dataWidth     = 8;                     // one register byte
  localparam int bankCount     = 8;
  localparam int bankDepth     = 16;                    // registers per bank
  localparam int regCount      = bankCount * bankDepth; // 0x00 to 0x7F
  localparam int idxWidth      = $clog2(bankDepth);     // low address nibble
  localparam int bankWidth     = $clog2(bankCount);
  localparam int regAddrWidth  = bankWidth + idxWidth;  // 7 bit register address

  //--------------------------------------------------------------------
  // types
  //--------------------------------------------------------------------
  typedef logic [rbcpAddrWidth-1:0]       rbcpAddrT;
  typedef logic [dataWidth-1:0]           byteT;
  typedef logic [bankCount-1:0]           bankSelT;   // one hot, bank 0 in bit 0
  typedef logic [idxWidth-1:0]            regIdxT;
  typedef logic [bankCount*dataWidth-1:0] bankRdT;    // bank 0 in low byte

  //--------------------------------------------------------------------
  // address map and identification
  //--------------------------------------------------------------------
  localparam int idRegCount = 5;                      // 0x00 to 0x04, read only

  // date code spread over 0x00 to 0x03, msb first
  localparam logic [(idRegCount-1)*dataWidth-1:0] synDate = 32'h0A1B_2C3D;
  localparam byteT fpgaVer = 8'h01;                    // at 0x04

  localparam logic [regAddrWidth-1:0] dipSwAddr = 7'h05; // switch status
  localparam logic [regAddrWidth-1:0] ledAddr   = 7'h06; // first writable entry

endpackage

`default_nettype wire

// File: hdl/rbcpRegTop.sv
//--------------------------------------------------------------------
// RBCP register file
// Decode, register storage and response stages between the RBCP
// slave and the board switches and LEDs
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module rbcpRegTop (
  input  wire logic                 CLK,
  input  wire logic                 RST,
  // RBCP
  input  wire rbcpRegPkg::rbcpAddrT rbcpAddr_i,
  input  wire logic                 rbcpWe_i,
  input  wire rbcpRegPkg::byteT     rbcpWd_i,
  input  wire logic                 rbcpRe_i,
  output wire rbcpRegPkg::byteT     rbcpRd_o,
  output wire logic                 rbcpAck_o,
  // board
  input  wire rbcpRegPkg::byteT     dipSw_i,
  output wire rbcpRegPkg::byteT     led_o
);

  import rbcpRegPkg::*;

  wire bankSelT bankSel;
  wire regIdxT  regIdx;
  wire logic    accWe;
  wire logic    accRe;
  wire byteT    accWd;
  wire bankRdT  bankRd;

  //--------------------------------------------------------------------
  // stages
  //--------------------------------------------------------------------
  rbcpDecode decode_i (
    .CLK        (CLK),
    .RST        (RST),
    .rbcpAddr_i (rbcpAddr_i),
    .rbcpWe_i   (rbcpWe_i),
    .rbcpRe_i   (rbcpRe_i),
    .rbcpWd_i   (rbcpWd_i),
    .bankSel_o  (bankSel),
    .regIdx_o   (regIdx),
    .accWe_o    (accWe),
    .accRe_o    (accRe),
    .accWd_o    (accWd)
  );

  regBank bank_i (
    .CLK       (CLK),
    .RST       (RST),
    .bankSel_i (bankSel),
    .regIdx_i  (regIdx),
    .accWe_i   (accWe),
    .accWd_i   (accWd),
    .dipSw_i   (dipSw_i),
    .bankRd_o  (bankRd),     // registered bank bytes
    .led_o     (led_o)
  );

  rbcpResponse response_i (
    .CLK       (CLK),
    .RST       (RST),
    .bankSel_i (bankSel),
    .accWe_i   (accWe),
    .accRe_i   (accRe),
    .bankRd_i  (bankRd),
    .rbcpRd_o  (rbcpRd_o),
    .rbcpAck_o (rbcpAck_o)
  );

endmodule

`default_nettype wire

// File: hdl/rbcpResponse.sv
//--------------------------------------------------------------------
// RBCP response pipeline
// Two stages that pick the addressed bank byte on reads and issue a
// one cycle acknowledge for every access inside the register window
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module rbcpResponse (
  input  wire logic                CLK,
  input  wire logic                RST,
  // decoded access
  input  wire rbcpRegPkg::bankSelT bankSel_i,
  input  wire logic                accWe_i,
  input  wire logic                accRe_i,
  // bank bytes, one stage behind the decode
  input  wire rbcpRegPkg::bankRdT  bankRd_i,
  // RBCP side
  output rbcpRegPkg::byteT         rbcpRd_o,
  output logic                     rbcpAck_o
);

  import rbcpRegPkg::*;

  bankSelT rdMask;     // banks whose byte goes out
  logic    ackPend;
  byteT    rdMerge;

  //--------------------------------------------------------------------
  // stage one
  //--------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      rdMask  <= '0;
      ackPend <= 1'b0;
    end else begin
      rdMask  <= accRe_i ? bankSel_i : '0;              // writes return no data
      ackPend <= (|bankSel_i) && (accWe_i || accRe_i);  // out of window stays silent
    end
  end

  //--------------------------------------------------------------------
  // stage two
  //--------------------------------------------------------------------
  // and-or merge, at most one mask bit is set
  always_comb begin
    rdMerge = '0;
    for (int b = 0; b < bankCount; b++) begin
      rdMerge |= bankRd_i[b*dataWidth +: dataWidth] & {dataWidth{rdMask[b]}};
    end
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      rbcpAck_o <= 1'b0;
      rbcpRd_o  <= '0;
    end else begin
      rbcpAck_o <= ackPend;
      rbcpRd_o  <= rdMerge;    // zero unless a read lands here
    end
  end

  //--------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------
  // an ack with no access right behind it must drop the next cycle
  ackSingleCycle : assert property (
    @(posedge CLK) disable iff (RST)
    rbcpAck_o && !$past(accWe_i || accRe_i, 1) |=> !rbcpAck_o
  ) else $error("ERROR rbcpAck_o held high: %h", rbcpAck_o);

endmodule

`default_nettype wire

// File: hdl/regBank.sv
//--------------------------------------------------------------------
// RBCP register storage
// 128 byte registers in 8 banks of 16, with read-only identification
// bytes, a sampled switch status byte and the LED register, and a
// registered read of the indexed byte from every bank
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module regBank (
  input  wire logic                CLK,
  input  wire logic                RST,
  // decoded access
  input  wire rbcpRegPkg::bankSelT bankSel_i,
  input  wire rbcpRegPkg::regIdxT  regIdx_i,
  input  wire logic                accWe_i,
  input  wire rbcpRegPkg::byteT    accWd_i,
  // board side
  input  wire rbcpRegPkg::byteT    dipSw_i,
  // read path and LEDs
  output rbcpRegPkg::bankRdT       bankRd_o,
  output rbcpRegPkg::byteT         led_o
);

  import rbcpRegPkg::*;

  byteT                    regs [regCount];     // flat register array
  logic [bankWidth-1:0]    wrBank;
  logic [regAddrWidth-1:0] wrAddr;
  logic                    wrHit;

  //--------------------------------------------------------------------
  // write address
  //--------------------------------------------------------------------
  // bank select back to a bank number
  always_comb begin
    wrBank = '0;
    for (int b = 0; b < bankCount; b++) begin
      if (bankSel_i[b]) begin
        wrBank = bankWidth'(b);
      end
    end
  end

  assign wrAddr = {wrBank, regIdx_i};

  // identification and switch status are not host writable
  assign wrHit = accWe_i && (|bankSel_i) && (wrAddr >= ledAddr);

  //--------------------------------------------------------------------
  // register array
  //--------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
      // date bytes, most significant at the lowest address
      for (int i = 0; i < idRegCount - 1; i++) begin
        regs[i] <= synDate[(idRegCount-2-i)*dataWidth +: dataWidth];
      end
      regs[idRegCount-1] <= fpgaVer;
    end else begin
      regs[dipSwAddr] <= dipSw_i;      // sampled every cycle
      if (wrHit) begin
        regs[wrAddr] <= accWd_i;
      end
    end
  end

  //--------------------------------------------------------------------
  // read path
  //--------------------------------------------------------------------
  // every bank presents its byte at the index, response picks one
  always_ff @(posedge CLK) begin
    for (int b = 0; b < bankCount; b++) begin
      bankRd_o[b*dataWidth +: dataWidth] <= regs[b*bankDepth + int'(regIdx_i)];
    end
  end

  assign led_o = regs[ledAddr];

  //--------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------
  logic [idRegCount*dataWidth-1:0] idVec;

  always_comb begin
    for (int i = 0; i < idRegCount; i++) begin
      idVec[i*dataWidth +: dataWidth] = regs[i];
    end
  end

  // no access path may alter the identification bytes
  idRegsStable : assert property (
    @(posedge CLK) disable iff (RST)
    $stable(idVec)
  ) else $error("ERROR idVec changed: %h -> %h", $past(idVec), idVec);

endmodule

`default_nettype wire

// File: testbench/rbcpRegTbTasks.svh
//--------------------------------------------------------------------
// RBCP register file testbench access tasks
// Single and burst RBCP accesses, acknowledge waits and the random
// number source used by the stimulus
//--------------------------------------------------------------------
`ifndef RBCP_REG_TB_TASKS_SVH
`define RBCP_REG_TB_TASKS_SVH

// linear congruential generator
function automatic logic [31:0] nextRandom();
  rngState = rngState * 32'd1664525 + 32'd1013904223;
  return rngState;
endfunction

function automatic int unsigned randBelow(input int unsigned n);
  return (nextRandom() >> 8) % n;   // low bits cycle too fast
endfunction

function automatic byteT randByte();
  return byteT'(nextRandom() >> 16);
endfunction

// block until the acknowledge count reaches target
task automatic waitAcks(input int target, input rbcpAddrT addr);
  int n;
  n = 0;
  while (ackSeen < target && n < 16) begin
    @(posedge CLK);
    n++;
  end
  if (ackSeen < target) begin
    timeoutErrors++;
    $display("timeout waiting for acknowledge at address %h", addr);
  end
endtask

task automatic writeReg(input rbcpAddrT addr, input byteT data);
  int target;
  target = ackSeen + 1;
  @(posedge CLK);
  rbcpAddr <= addr;
  rbcpWd   <= data;
  rbcpWe   <= 1'b1;
  @(posedge CLK);
  rbcpWe   <= 1'b0;                 // one cycle strobe
  waitAcks(target, addr);
endtask

task automatic readReg(input rbcpAddrT addr);
  int target;
  target = ackSeen + 1;
  @(posedge CLK);
  rbcpAddr <= addr;
  rbcpRe   <= 1'b1;
  @(posedge CLK);
  rbcpRe   <= 1'b0;
  waitAcks(target, addr);
endtask

// reads on consecutive cycles, data checked in request order
task automatic burstRead(input logic [6:0] base, input int count);
  int target;
  target = ackSeen + count;
  for (int i = 0; i < count; i++) begin
    @(posedge CLK);
    rbcpAddr <= rbcpAddrT'(base + 7'(i));
    rbcpRe   <= 1'b1;
  end
  @(posedge CLK);
  rbcpRe <= 1'b0;
  waitAcks(target, rbcpAddrT'(base));
endtask

// out of window access, ack pipeline check flags any response
task automatic probeNoAck(input rbcpAddrT addr, input logic isWrite);
  @(posedge CLK);
  rbcpAddr <= addr;
  rbcpWd   <= randByte();
  rbcpWe   <= isWrite;
  rbcpRe   <= !isWrite;
  @(posedge CLK);
  rbcpWe   <= 1'b0;
  rbcpRe   <= 1'b0;
  for (int n = 0; n < 8; n++) begin
    @(posedge CLK);
  end
endtask

`endif

// File: testbench/rbcpRegTb.sv
//--------------------------------------------------------------------
// RBCP register file testbench
// Drives register accesses into the DUT, mirrors them in a byte
// model and checks acknowledge, read data and LEDs every cycle
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module rbcpRegTb;

  import rbcpRegPkg::*;

  logic        CLK;
  logic        RST;
  rbcpAddrT    rbcpAddr;
  logic        rbcpWe;
  logic        rbcpRe;
  byteT        rbcpWd;
  byteT        dipSw;
  wire byteT   rbcpRd;
  wire logic   rbcpAck;
  wire byteT   led;

  logic [31:0] rngState = 32'd76;  // fixed seed
  int          ackSeen = 0;
  int          ackErrors = 0;
  int          rdErrors = 0;
  int          ledErrors = 0;
  int          timeoutErrors = 0;

  // reference model state
  byteT        model [128];
  logic [2:0]  ackPipe;          // expected ack, one stage per edge
  byteT        rdPipe [3];
  byteT        ledNext;
  byteT        ledExp;
  logic        hit;
  byteT        rdVal;

  `include "rbcpRegTbTasks.svh"

  rbcpRegTop dut_i (
    .CLK        (CLK),
    .RST        (RST),
    .rbcpAddr_i (rbcpAddr),
    .rbcpWe_i   (rbcpWe),
    .rbcpWd_i   (rbcpWd),
    .rbcpRe_i   (rbcpRe),
    .rbcpRd_o   (rbcpRd),
    .rbcpAck_o  (rbcpAck),
    .dipSw_i    (dipSw),
    .led_o      (led)
  );

  always #10 CLK = ~CLK;

  always @(negedge CLK) begin
    if (rbcpAck) begin
      ackSeen++;
    end
  end

  //--------------------------------------------------------------------
  // reference model
  //--------------------------------------------------------------------
  always @(posedge CLK) begin
    if (RST) begin
      for (int i = 0; i < 128; i++) begin
        model[i] = '0;
      end
      for (int i = 0; i < 4; i++) begin
        model[i] = synDate[31-8*i -: 8];  // msb at 0x00
      end
      model[4] = fpgaVer;
      ackPipe <= '0;
      rdPipe  <= '{default: '0};
      ledNext <= '0;
      ledExp  <= '0;
    end else begin
      hit   = (rbcpWe || rbcpRe) && (rbcpAddr < 128);
      rdVal = '0;
      if (hit && rbcpRe) begin
        rdVal = (rbcpAddr == 5) ? dipSw : model[rbcpAddr[6:0]];
      end
      if (hit && rbcpWe && rbcpAddr >= 6) begin
        model[rbcpAddr[6:0]] = rbcpWd;   // 0x00 to 0x05 read only
      end
      ackPipe   <= {ackPipe[1:0], hit};
      rdPipe[0] <= rdVal;
      rdPipe[1] <= rdPipe[0];
      rdPipe[2] <= rdPipe[1];
      ledNext   <= model[6];
      ledExp    <= ledNext;            // LED follows one edge after the write
    end
  end

  //--------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------
  ackMatch : assert property (@(posedge CLK) disable iff (RST) rbcpAck == ackPipe[2])
    else begin
      ackErrors++;
      $display("ERROR rbcpAck_o: got %h, expected %h", $sampled(rbcpAck), $sampled(ackPipe[2]));
    end

  rdMatch : assert property (@(posedge CLK) disable iff (RST) rbcpRd == rdPipe[2])
    else begin
      rdErrors++;
      $display("ERROR rbcpRd_o: got %h, expected %h", $sampled(rbcpRd), $sampled(rdPipe[2]));
    end

  rdIdleZero : assert property (@(posedge CLK) disable iff (RST) !rbcpAck |-> rbcpRd == '0)
    else begin
      rdErrors++;
      $display("ERROR rbcpRd_o: got %h, expected %h while idle", $sampled(rbcpRd), 8'h00);
    end

  ledMatch : assert property (@(posedge CLK) disable iff (RST) led == ledExp)
    else begin
      ledErrors++;
      $display("ERROR led_o: got %h, expected %h", $sampled(led), $sampled(ledExp));
    end

  //--------------------------------------------------------------------
  // stimulus
  //--------------------------------------------------------------------
  initial begin
    logic [6:0] addrList [24];
    logic [6:0] swap;
    int unsigned j;
    byteT sw;
    int errTotal;
    CLK      = 1'b0;
    RST      = 1'b1;
    rbcpAddr = '0;
    rbcpWe   = 1'b0;
    rbcpRe   = 1'b0;
    rbcpWd   = '0;
    dipSw    = '0;
    repeat (4) @(posedge CLK);
    RST <= 1'b0;

    // identification bytes, then attempted overwrites
    for (int i = 0; i < idRegCount; i++) readReg(i);
    for (int i = 0; i < idRegCount; i++) writeReg(i, randByte());
    for (int i = 0; i < idRegCount; i++) readReg(i);

    // switch status
    repeat (4) begin
      sw = randByte();
      @(posedge CLK);
      dipSw <= sw;
      repeat (2) @(posedge CLK);
      readReg(dipSwAddr);
      writeReg(dipSwAddr, ~sw);
      readReg(dipSwAddr);
    end

    // random writes, read back shuffled
    writeReg(ledAddr, randByte());
    for (int i = 0; i < 24; i++) begin
      addrList[i] = 7'(6 + randBelow(122));
      writeReg(addrList[i], randByte());
    end
    for (int i = 23; i > 0; i--) begin
      j = randBelow(i + 1);
      swap        = addrList[i];
      addrList[i] = addrList[j];
      addrList[j] = swap;
    end
    for (int i = 0; i < 24; i++) readReg(addrList[i]);
    readReg(ledAddr);

    // back to back reads, crossing a bank boundary
    burstRead(7'h00, 8);
    burstRead(7'h0C, 8);
    burstRead(7'h78, 8);

    // outside the register window
    probeNoAck(32'h0000_0080, 1'b1);
    probeNoAck(32'h0000_01FF, 1'b0);
    probeNoAck(32'h8000_0006, 1'b1);
    probeNoAck(32'h0000_0100, 1'b0);
    readReg(ledAddr);
    repeat (4) @(posedge CLK);

    errTotal = ackErrors + rdErrors + ledErrors + timeoutErrors;
    $display("errors: ack %0d, read data %0d, led %0d, timeout %0d",
             ackErrors, rdErrors, ledErrors, timeoutErrors);
    if (errTotal == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+testbench
hdl/rbcpRegPkg.sv
hdl/rbcpDecode.sv
hdl/regBank.sv
hdl/rbcpResponse.sv
hdl/rbcpRegTop.sv
testbench/rbcpRegTb.sv
